// ==== include/cluster_periph_defs.svh ====
// Sizes, address map, register offsets and reset values, included by every design file
`ifndef CLUSTER_PERIPH_DEFS_SVH
`define CLUSTER_PERIPH_DEFS_SVH

// Cluster size and request id width (one id bit per core plus one)
`define NB_CORES        4
`define PERIPH_ID_WIDTH 5
`define EVNT_WIDTH      8

`define BOOT_ADDR_RST   32'h1C000000

// Address bits that pick the target block
`define ADDR_SEL_MSB    11
`define ADDR_SEL_LSB    10

// Register offsets inside each block, bits 5..2 of the address
`define CTRL_EOC_OFFS   6'h00
`define CTRL_FETCH_OFFS 6'h08
`define CTRL_BOOT_OFFS  6'h10
`define TIMER_CNT_OFFS  6'h00
`define TIMER_CMP_OFFS  6'h04
`define TIMER_CFG_OFFS  6'h08
`define EU_MASK_OFFS    6'h00
`define EU_BUFFER_OFFS  6'h10
`define EU_CLEAR_OFFS   6'h20

`define ERR_RDATA       32'hDEADB33F

`endif

// ==== verilog/cluster_periph_pkg.sv ====
// Shared types and helpers for the cluster peripheral block, referenced by scoped name
`include "cluster_periph_defs.svh"

package cluster_periph_pkg;

  // Block selected by address bits 11..10
  typedef enum logic [1:0] {
    TGT_CTRL  = 2'd0,
    TGT_TIMER = 2'd1,
    TGT_EU    = 2'd2,
    TGT_NONE  = 2'd3
  } periph_target_e;

  // Per-core events: 0 timer, 1 mailbox, 5..2 accelerator, 6 DMA event, 7 DMA irq
  typedef logic [`EVNT_WIDTH-1:0] evt_vec_t;

  typedef struct packed {
    logic                        valid;
    logic [31:0]                 rdata;
    logic                        opc;
    logic [`PERIPH_ID_WIDTH-1:0] id;
  } periph_resp_t;

  // Byte-enabled register update
  function automatic logic [31:0] be_merge(input logic [31:0] old_v,
                                           input logic [31:0] new_v,
                                           input logic [3:0]  be);
    logic [31:0] res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_v[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

// ==== verilog/periph_bus_if.sv ====
// Peripheral bus carrying one request and its response between decode, blocks and result stage
`include "cluster_periph_defs.svh"

interface periph_bus_if;

  // Request side
  logic                        req;
  logic [31:0]                 add;
  logic                        wen;
  logic [31:0]                 wdata;
  logic [3:0]                  be;
  logic [`PERIPH_ID_WIDTH-1:0] id;

  // Response side
  logic                        gnt;
  logic                        r_valid;
  logic [31:0]                 r_rdata;
  logic                        r_opc;
  logic [`PERIPH_ID_WIDTH-1:0] r_id;

  modport master (output req, add, wen, wdata, be, id,
                  input  gnt, r_valid, r_rdata, r_opc, r_id);

  modport slave (input  req, add, wen, wdata, be, id,
                 output gnt, r_valid, r_rdata, r_opc, r_id);

  modport monitor (input req, add, wen, wdata, be, id,
                   input gnt, r_valid, r_rdata, r_opc, r_id);

endinterface

// ==== verilog/periph_addr_decode.sv ====
// Decode stage, routes each accepted request to one block by address and flags unmapped ones
`include "cluster_periph_defs.svh"

module periph_addr_decode (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               req_i,
  input  logic [31:0]                        add_i,
  input  logic                               wen_i,
  input  logic [31:0]                        wdata_i,
  input  logic [3:0]                         be_i,
  input  logic [`PERIPH_ID_WIDTH-1:0]        id_i,
  output logic                               gnt_o,
  periph_bus_if.master                       ctrl_bus,
  periph_bus_if.master                       timer_bus,
  periph_bus_if.master                       eu_bus,
  output logic                               err_valid_o,
  output logic [`PERIPH_ID_WIDTH-1:0]        err_id_o,
  output cluster_periph_pkg::periph_target_e sel_o
);

  cluster_periph_pkg::periph_target_e tgt;
  logic                               accept;
  logic                               gnt_q;

  assign tgt    = cluster_periph_pkg::periph_target_e'(add_i[`ADDR_SEL_MSB:`ADDR_SEL_LSB]);
  assign accept = req_i & gnt_q;
  assign gnt_o  = gnt_q;

  // Request fields go to every block, only req is steered
  assign ctrl_bus.add    = add_i;
  assign ctrl_bus.wen    = wen_i;
  assign ctrl_bus.wdata  = wdata_i;
  assign ctrl_bus.be     = be_i;
  assign ctrl_bus.id     = id_i;
  assign ctrl_bus.req    = accept & (tgt == cluster_periph_pkg::TGT_CTRL);

  assign timer_bus.add   = add_i;
  assign timer_bus.wen   = wen_i;
  assign timer_bus.wdata = wdata_i;
  assign timer_bus.be    = be_i;
  assign timer_bus.id    = id_i;
  assign timer_bus.req   = accept & (tgt == cluster_periph_pkg::TGT_TIMER);

  assign eu_bus.add      = add_i;
  assign eu_bus.wen      = wen_i;
  assign eu_bus.wdata    = wdata_i;
  assign eu_bus.be       = be_i;
  assign eu_bus.id       = id_i;
  assign eu_bus.req      = accept & (tgt == cluster_periph_pkg::TGT_EU);

  // Grant once all blocks are ready, error flag and select for the next cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gnt_q       <= 1'b0;
      err_valid_o <= 1'b0;
      sel_o       <= cluster_periph_pkg::TGT_NONE;
    end else begin
      gnt_q       <= ctrl_bus.gnt & timer_bus.gnt & eu_bus.gnt;
      err_valid_o <= accept & (tgt == cluster_periph_pkg::TGT_NONE);
      sel_o       <= tgt;
    end
  end

  always_ff @(posedge clk_i) begin
    err_id_o <= id_i;
  end

endmodule

// ==== verilog/cluster_ctrl_unit.sv ====
// Cluster control unit, holds end of computation, fetch enables and per-core boot addresses
`include "cluster_periph_defs.svh"

module cluster_ctrl_unit (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  periph_bus_if.slave                    bus,
  output logic                           eoc_o,
  output logic [`NB_CORES-1:0]           fetch_enable_o,
  output logic [`NB_CORES-1:0][31:0]     boot_addr_o
);

  logic [5:0]                        offs;
  logic                              wr;
  logic                              eoc_q;
  logic [`NB_CORES-1:0]              fetch_q;
  logic [`NB_CORES-1:0][31:0]        boot_q;
  logic [31:0]                       rdata_d;
  logic                              r_valid_q;
  logic [31:0]                       r_rdata_q;
  logic [`PERIPH_ID_WIDTH-1:0]       r_id_q;

  assign offs = {bus.add[5:2], 2'b00};
  assign wr   = bus.req & ~bus.wen;

  // Single-cycle block, always ready
  assign bus.gnt = 1'b1;

  // Read mux, writes and undefined offsets return zero
  always_comb begin
    rdata_d = '0;
    if (offs == `CTRL_EOC_OFFS) begin
      rdata_d[0] = eoc_q;
    end
    if (offs == `CTRL_FETCH_OFFS) begin
      rdata_d[`NB_CORES-1:0] = fetch_q;
    end
    for (int c = 0; c < `NB_CORES; c++) begin
      if (offs == 6'(`CTRL_BOOT_OFFS + 4 * c)) begin
        rdata_d = boot_q[c];
      end
    end
    if (!bus.wen) begin
      rdata_d = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eoc_q     <= 1'b0;
      fetch_q   <= '0;
      boot_q    <= {`NB_CORES{`BOOT_ADDR_RST}};
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus.req;
      if (wr && offs == `CTRL_EOC_OFFS && bus.be[0]) begin
        eoc_q <= bus.wdata[0];
      end
      if (wr && offs == `CTRL_FETCH_OFFS && bus.be[0]) begin
        fetch_q <= bus.wdata[`NB_CORES-1:0];
      end
      for (int c = 0; c < `NB_CORES; c++) begin
        if (wr && offs == 6'(`CTRL_BOOT_OFFS + 4 * c)) begin
          boot_q[c] <= cluster_periph_pkg::be_merge(boot_q[c], bus.wdata, bus.be);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    r_rdata_q <= rdata_d;
    r_id_q    <= bus.id;
  end

  assign bus.r_valid    = r_valid_q;
  assign bus.r_rdata    = r_rdata_q;
  assign bus.r_opc      = 1'b0;
  assign bus.r_id       = r_id_q;

  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fetch_q;
  assign boot_addr_o    = boot_q;

endmodule

// ==== verilog/cluster_timer.sv ====
// Cluster timer, free-running count with compare match, wrap and a one-cycle event
`include "cluster_periph_defs.svh"

module cluster_timer (
  input  logic        clk_i,
  input  logic        rst_n_i,
  periph_bus_if.slave bus,
  output logic        timer_evt_o
);

  logic [5:0]                  offs;
  logic                        wr;
  logic [31:0]                 cnt_q;
  logic [31:0]                 cmp_q;
  logic                        en_q;
  logic                        match;
  logic [31:0]                 rdata_d;
  logic                        r_valid_q;
  logic [31:0]                 r_rdata_q;
  logic [`PERIPH_ID_WIDTH-1:0] r_id_q;

  assign offs    = {bus.add[5:2], 2'b00};
  assign wr      = bus.req & ~bus.wen;
  assign bus.gnt = 1'b1;

  // Match only counts while running
  assign match = en_q & (cnt_q == cmp_q);

  always_comb begin
    rdata_d = '0;
    case (offs)
      `TIMER_CNT_OFFS: rdata_d = cnt_q;
      `TIMER_CMP_OFFS: rdata_d = cmp_q;
      `TIMER_CFG_OFFS: rdata_d[0] = en_q;
      default:         rdata_d = '0;
    endcase
    if (!bus.wen) begin
      rdata_d = '0;
    end
  end

  // ******************************
  // Counter, compare and config
  // ******************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q       <= '0;
      cmp_q       <= '1;
      en_q        <= 1'b0;
      timer_evt_o <= 1'b0;
      r_valid_q   <= 1'b0;
    end else begin
      r_valid_q   <= bus.req;
      timer_evt_o <= match;
      // Bus write beats wrap and increment
      if (wr && offs == `TIMER_CNT_OFFS) begin
        cnt_q <= cluster_periph_pkg::be_merge(cnt_q, bus.wdata, bus.be);
      end else if (match) begin
        cnt_q <= '0;
      end else if (en_q) begin
        cnt_q <= cnt_q + 32'd1;
      end
      if (wr && offs == `TIMER_CMP_OFFS) begin
        cmp_q <= cluster_periph_pkg::be_merge(cmp_q, bus.wdata, bus.be);
      end
      if (wr && offs == `TIMER_CFG_OFFS && bus.be[0]) begin
        en_q <= bus.wdata[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    r_rdata_q <= rdata_d;
    r_id_q    <= bus.id;
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_rdata = r_rdata_q;
  assign bus.r_opc   = 1'b0;
  assign bus.r_id    = r_id_q;

endmodule

// ==== verilog/event_unit.sv ====
// Event unit, buffers per-core events, applies masks and write-one clears, raises interrupts
`include "cluster_periph_defs.svh"

module event_unit (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  periph_bus_if.slave                  bus,
  input  logic                         timer_evt_i,
  input  logic                         mbox_irq_i,
  input  logic [`NB_CORES-1:0][3:0]    acc_events_i,
  input  logic [`NB_CORES-1:0]         dma_event_i,
  input  logic [`NB_CORES-1:0]         dma_irq_i,
  output logic [`NB_CORES-1:0]         irq_req_o
);

  logic [5:0]                     offs;
  logic                           wr;
  cluster_periph_pkg::evt_vec_t   evt    [`NB_CORES];
  cluster_periph_pkg::evt_vec_t   clr    [`NB_CORES];
  cluster_periph_pkg::evt_vec_t   buf_q  [`NB_CORES];
  cluster_periph_pkg::evt_vec_t   mask_q [`NB_CORES];
  logic [31:0]                    rdata_d;
  logic                           r_valid_q;
  logic [31:0]                    r_rdata_q;
  logic [`PERIPH_ID_WIDTH-1:0]    r_id_q;

  assign offs    = {bus.add[5:2], 2'b00};
  assign wr      = bus.req & ~bus.wen;
  assign bus.gnt = 1'b1;

  // Shared timer and mailbox, per-core accelerator and DMA sources
  for (genvar c = 0; c < `NB_CORES; c++) begin : g_evt
    assign evt[c] = {dma_irq_i[c], dma_event_i[c], acc_events_i[c], mbox_irq_i, timer_evt_i};
  end

  always_comb begin
    rdata_d = '0;
    for (int c = 0; c < `NB_CORES; c++) begin
      clr[c] = '0;
      if (wr && bus.be[0] && offs == 6'(`EU_CLEAR_OFFS + 4 * c)) begin
        clr[c] = bus.wdata[`EVNT_WIDTH-1:0];
      end
      if (offs == 6'(`EU_MASK_OFFS + 4 * c)) begin
        rdata_d[`EVNT_WIDTH-1:0] = mask_q[c];
      end
      if (offs == 6'(`EU_BUFFER_OFFS + 4 * c)) begin
        rdata_d[`EVNT_WIDTH-1:0] = buf_q[c];
      end
    end
    if (!bus.wen) begin
      rdata_d = '0;
    end
  end

  // ******************************
  // Buffers, masks and interrupts
  // ******************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      buf_q     <= '{default: '0};
      mask_q    <= '{default: '0};
      irq_req_o <= '0;
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus.req;
      for (int c = 0; c < `NB_CORES; c++) begin
        // New events win over a clear in the same cycle
        buf_q[c]     <= (buf_q[c] & ~clr[c]) | evt[c];
        irq_req_o[c] <= |(buf_q[c] & mask_q[c]);
        if (wr && bus.be[0] && offs == 6'(`EU_MASK_OFFS + 4 * c)) begin
          mask_q[c] <= bus.wdata[`EVNT_WIDTH-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    r_rdata_q <= rdata_d;
    r_id_q    <= bus.id;
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_rdata = r_rdata_q;
  assign bus.r_opc   = 1'b0;
  assign bus.r_id    = r_id_q;

endmodule

// ==== verilog/periph_resp_mux.sv ====
// Result stage, merges block responses and unmapped errors onto the single response port
`include "cluster_periph_defs.svh"

module periph_resp_mux (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  cluster_periph_pkg::periph_target_e sel_i,
  input  logic                               err_valid_i,
  input  logic [`PERIPH_ID_WIDTH-1:0]        err_id_i,
  periph_bus_if.monitor                      ctrl_bus,
  periph_bus_if.monitor                      timer_bus,
  periph_bus_if.monitor                      eu_bus,
  output logic                               r_valid_o,
  output logic [31:0]                        r_rdata_o,
  output logic                               r_opc_o,
  output logic [`PERIPH_ID_WIDTH-1:0]        r_id_o
);

  cluster_periph_pkg::periph_resp_t resp;
  cluster_periph_pkg::periph_resp_t last_q;

  always_comb begin
    case (sel_i)
      cluster_periph_pkg::TGT_CTRL:
        resp = '{ctrl_bus.r_valid, ctrl_bus.r_rdata, ctrl_bus.r_opc, ctrl_bus.r_id};
      cluster_periph_pkg::TGT_TIMER:
        resp = '{timer_bus.r_valid, timer_bus.r_rdata, timer_bus.r_opc, timer_bus.r_id};
      cluster_periph_pkg::TGT_EU:
        resp = '{eu_bus.r_valid, eu_bus.r_rdata, eu_bus.r_opc, eu_bus.r_id};
      default:
        resp = '{err_valid_i, `ERR_RDATA, err_valid_i, err_id_i};
    endcase
  end

  // Keep the last payload on the port between responses
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_q <= '0;
    end else if (resp.valid) begin
      last_q <= resp;
    end
  end

  assign r_valid_o = resp.valid;
  assign r_rdata_o = resp.valid ? resp.rdata : last_q.rdata;
  assign r_opc_o   = resp.valid ? resp.opc : last_q.opc;
  assign r_id_o    = resp.valid ? resp.id : last_q.id;

endmodule

// ==== verilog/cluster_periph_top.sv ====
// Top level of the cluster peripheral block, plain bus ports around decode, blocks and result
`include "cluster_periph_defs.svh"

module cluster_periph_top (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Request port
  input  logic                           req_i,
  input  logic [31:0]                    add_i,
  input  logic                           wen_i,
  input  logic [31:0]                    wdata_i,
  input  logic [3:0]                     be_i,
  input  logic [`PERIPH_ID_WIDTH-1:0]    id_i,
  // Response port
  output logic                           gnt_o,
  output logic                           r_valid_o,
  output logic [31:0]                    r_rdata_o,
  output logic                           r_opc_o,
  output logic [`PERIPH_ID_WIDTH-1:0]    r_id_o,
  // Event sources
  input  logic                           mbox_irq_i,
  input  logic [`NB_CORES-1:0][3:0]      acc_events_i,
  input  logic [`NB_CORES-1:0]           dma_event_i,
  input  logic [`NB_CORES-1:0]           dma_irq_i,
  // Core control
  output logic                           eoc_o,
  output logic [`NB_CORES-1:0]           fetch_enable_o,
  output logic [`NB_CORES-1:0][31:0]     boot_addr_o,
  output logic [`NB_CORES-1:0]           irq_req_o
);

  cluster_periph_pkg::periph_target_e sel;
  logic                               err_valid;
  logic [`PERIPH_ID_WIDTH-1:0]        err_id;
  logic                               timer_evt;

  periph_bus_if ctrl_bus ();
  periph_bus_if timer_bus ();
  periph_bus_if eu_bus ();

  // ******************************
  // Decode
  // ******************************
  periph_addr_decode u_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .add_i       (add_i),
    .wen_i       (wen_i),
    .wdata_i     (wdata_i),
    .be_i        (be_i),
    .id_i        (id_i),
    .gnt_o       (gnt_o),
    .ctrl_bus    (ctrl_bus.master),
    .timer_bus   (timer_bus.master),
    .eu_bus      (eu_bus.master),
    .err_valid_o (err_valid),
    .err_id_o    (err_id),
    .sel_o       (sel)
  );

  // ******************************
  // Register blocks
  // ******************************
  cluster_ctrl_unit u_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .bus            (ctrl_bus.slave),
    .eoc_o          (eoc_o),
    .fetch_enable_o (fetch_enable_o),
    .boot_addr_o    (boot_addr_o)
  );

  cluster_timer u_timer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus         (timer_bus.slave),
    .timer_evt_o (timer_evt)
  );

  event_unit u_eu (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .bus          (eu_bus.slave),
    .timer_evt_i  (timer_evt),
    .mbox_irq_i   (mbox_irq_i),
    .acc_events_i (acc_events_i),
    .dma_event_i  (dma_event_i),
    .dma_irq_i    (dma_irq_i),
    .irq_req_o    (irq_req_o)
  );

  // ******************************
  // Result
  // ******************************
  periph_resp_mux u_resp (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .sel_i       (sel),
    .err_valid_i (err_valid),
    .err_id_i    (err_id),
    .ctrl_bus    (ctrl_bus.monitor),
    .timer_bus   (timer_bus.monitor),
    .eu_bus      (eu_bus.monitor),
    .r_valid_o   (r_valid_o),
    .r_rdata_o   (r_rdata_o),
    .r_opc_o     (r_opc_o),
    .r_id_o      (r_id_o)
  );

endmodule

// ==== tests/cluster_periph_chk.sv ====
// Bus timing assertions for the cluster peripheral top level, attached with bind
`include "cluster_periph_defs.svh"

module cluster_periph_chk (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic                        req_i,
  input logic                        gnt_o,
  input logic [`PERIPH_ID_WIDTH-1:0] id_i,
  input logic                        r_valid_o,
  input logic [`PERIPH_ID_WIDTH-1:0] r_id_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // One response per accepted request, one cycle later, same id
  a_resp_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_i && gnt_o) |=> (r_valid_o && r_id_o == $past(id_i)))
    else $error("Accepted request not answered one cycle later with its id");

  // No response without an accepted request
  a_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o |-> $past(req_i && gnt_o))
    else $error("Response without an accepted request in the previous cycle");

  a_gnt_high: assert property (@(posedge clk_i)
    $past(rst_n_i) |-> gnt_o)
    else $error("Grant low although reset was released in the previous cycle");

endmodule

bind cluster_periph_top cluster_periph_chk u_chk (.*);

// ==== tests/cluster_periph_tb.sv ====
// Testbench for the cluster peripheral block that checks random bus traffic against a cycle model
`include "cluster_periph_defs.svh"

module cluster_periph_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic clk_i, rst_n_i, req_i, wen_i, mbox_irq_i;
  logic [31:0] add_i, wdata_i;
  logic [3:0] be_i;
  logic [`PERIPH_ID_WIDTH-1:0] id_i, r_id_o;
  logic [`NB_CORES-1:0][3:0] acc_events_i;
  logic [`NB_CORES-1:0] dma_event_i, dma_irq_i, fetch_enable_o, irq_req_o;
  logic gnt_o, r_valid_o, r_opc_o, eoc_o;
  logic [31:0] r_rdata_o;
  logic [`NB_CORES-1:0][31:0] boot_addr_o;

  // Register model
  logic m_gnt, m_eoc, m_en, m_tevt;
  logic [`NB_CORES-1:0] m_fetch, m_irq;
  logic [31:0] m_boot [`NB_CORES];
  logic [31:0] m_cnt, m_cmp;
  logic [7:0] m_buf [`NB_CORES];
  logic [7:0] m_mask [`NB_CORES];
  cluster_periph_pkg::periph_resp_t m_resp;

  int errors = 0;
  int checks = 0;
  int n;
  string test_name;

  cluster_periph_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_v, input logic [31:0] new_v,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

  // ******************************
  // Cycle model stepped at each rising edge
  // ******************************
  task automatic step_model();
    logic accept, wr, match;
    logic [1:0] sel;
    logic [5:0] offs;
    logic [7:0] evt, clr;
    logic [31:0] rd;
    if (!rst_n_i) begin
      m_gnt = 1'b0;
      m_eoc = 1'b0;
      m_fetch = '0;
      m_en = 1'b0;
      m_tevt = 1'b0;
      m_cnt = '0;
      m_cmp = '1;
      m_irq = '0;
      m_resp = '0;
      for (int c = 0; c < `NB_CORES; c++) begin
        m_boot[c] = `BOOT_ADDR_RST;
        m_buf[c] = '0;
        m_mask[c] = '0;
      end
      return;
    end
    accept = req_i & m_gnt;
    sel = add_i[11:10];
    offs = {add_i[5:2], 2'b00};
    wr = accept & ~wen_i;
    rd = '0;
    case (sel)
      2'd0: begin
        if (offs == 6'h00) rd[0] = m_eoc;
        if (offs == 6'h08) rd[`NB_CORES-1:0] = m_fetch;
        for (int c = 0; c < `NB_CORES; c++) begin
          if (offs == 6'(16 + 4 * c)) rd = m_boot[c];
        end
      end
      2'd1: begin
        if (offs == 6'h00) rd = m_cnt;
        if (offs == 6'h04) rd = m_cmp;
        if (offs == 6'h08) rd[0] = m_en;
      end
      2'd2: begin
        for (int c = 0; c < `NB_CORES; c++) begin
          if (offs == 6'(4 * c)) rd[7:0] = m_mask[c];
          if (offs == 6'(16 + 4 * c)) rd[7:0] = m_buf[c];
        end
      end
      default: rd = `ERR_RDATA;
    endcase
    // Writes answer with zero data
    if (!wen_i && sel != 2'd3) rd = '0;
    m_resp.valid = accept;
    m_resp.rdata = rd;
    m_resp.opc = (sel == 2'd3);
    m_resp.id = id_i;
    if (wr && sel == 2'd0) begin
      if (offs == 6'h00 && be_i[0]) m_eoc = wdata_i[0];
      if (offs == 6'h08 && be_i[0]) m_fetch = wdata_i[`NB_CORES-1:0];
      for (int c = 0; c < `NB_CORES; c++) begin
        if (offs == 6'(16 + 4 * c)) m_boot[c] = merge_bytes(m_boot[c], wdata_i, be_i);
      end
    end
    match = m_en && (m_cnt == m_cmp);
    for (int c = 0; c < `NB_CORES; c++) begin
      evt = {dma_irq_i[c], dma_event_i[c], acc_events_i[c], mbox_irq_i, m_tevt};
      clr = (wr && sel == 2'd2 && be_i[0] && offs == 6'(32 + 4 * c)) ? wdata_i[7:0] : 8'h00;
      m_irq[c] = |(m_buf[c] & m_mask[c]);
      m_buf[c] = (m_buf[c] & ~clr) | evt;
      if (wr && sel == 2'd2 && be_i[0] && offs == 6'(4 * c)) m_mask[c] = wdata_i[7:0];
    end
    m_tevt = match;
    if (wr && sel == 2'd1 && offs == 6'h00) m_cnt = merge_bytes(m_cnt, wdata_i, be_i);
    else if (match) m_cnt = '0;
    else if (m_en) m_cnt = m_cnt + 32'd1;
    if (wr && sel == 2'd1 && offs == 6'h04) m_cmp = merge_bytes(m_cmp, wdata_i, be_i);
    if (wr && sel == 2'd1 && offs == 6'h08 && be_i[0]) m_en = wdata_i[0];
    m_gnt = 1'b1;
  endtask

  task automatic compare_val(input string what, input logic [31:0] exp_v, input logic [31:0] act);
    checks++;
    if (exp_v !== act) begin
      errors++;
      $display("Mismatch %s %s: expected %h actual %h", test_name, what, exp_v, act);
    end
  endtask

  task automatic check_outputs();
    compare_val("gnt_o", 32'(m_gnt), 32'(gnt_o));
    if (m_resp.valid && !r_valid_o) begin
      errors++;
      $display("Response for id %0d did not arrive in %s", m_resp.id, test_name);
    end else if (!m_resp.valid && r_valid_o) begin
      errors++;
      $display("Response with id %0d arrived without a request in %s", r_id_o, test_name);
    end else if (m_resp.valid) begin
      compare_val("r_rdata_o", m_resp.rdata, r_rdata_o);
      compare_val("r_opc_o", 32'(m_resp.opc), 32'(r_opc_o));
      compare_val("r_id_o", 32'(m_resp.id), 32'(r_id_o));
    end
    compare_val("eoc_o", 32'(m_eoc), 32'(eoc_o));
    compare_val("fetch_enable_o", 32'(m_fetch), 32'(fetch_enable_o));
    compare_val("irq_req_o", 32'(m_irq), 32'(irq_req_o));
    for (int c = 0; c < `NB_CORES; c++) begin
      compare_val("boot_addr_o", m_boot[c], boot_addr_o[c]);
    end
  endtask

  // One bus cycle that models the edge, drives the next request and checks at the falling edge
  task automatic tick(input logic rq, input logic [1:0] sel, input logic [3:0] word,
                      input logic we, input logic [31:0] wd, input logic [3:0] be,
                      input logic ev_on);
    logic [31:0] a;
    a = $urandom;
    a[11:10] = sel;
    a[5:2] = word;
    a[1:0] = 2'b00;
    @(posedge clk_i);
    step_model();
    rst_n_i <= 1'b1;
    req_i <= rq;
    add_i <= a;
    wen_i <= we;
    wdata_i <= wd;
    be_i <= be;
    id_i <= `PERIPH_ID_WIDTH'($urandom);
    mbox_irq_i <= ev_on && ($urandom % 8 == 0);
    acc_events_i <= ev_on ? 16'($urandom & $urandom & $urandom) : 16'h0;
    dma_event_i <= ev_on ? 4'($urandom & $urandom) : 4'h0;
    dma_irq_i <= ev_on ? 4'($urandom & $urandom & $urandom) : 4'h0;
    @(negedge clk_i);
    check_outputs();
  endtask

  initial begin
    void'($urandom(32'hf50ab7f3));
    rst_n_i = 1'b0;
    req_i = 1'b0;
    add_i = '0;
    wen_i = 1'b1;
    wdata_i = '0;
    be_i = '0;
    id_i = '0;
    mbox_irq_i = 1'b0;
    acc_events_i = '0;
    dma_event_i = '0;
    dma_irq_i = '0;
    test_name = "reset";
    @(posedge clk_i);
    tick(0, 0, 0, 1, 0, 0, 0);
    n = 0;
    while (!gnt_o && n < 10) begin
      tick(0, 0, 0, 1, 0, 0, 0);
      n++;
    end
    if (!gnt_o) begin
      errors++;
      $display("Timeout: gnt_o stayed low after reset");
    end

    test_name = "ctrl_regs";
    repeat (60) tick(1, 0, 4'($urandom % 8), 1'($urandom), $urandom, 4'($urandom), 0);
    tick(1, 0, 0, 0, 32'h1, 4'hF, 0);

    test_name = "unmapped";
    repeat (40) tick(1, ($urandom % 2) ? 2'd3 : 2'd0, 4'($urandom % 8), 1'($urandom),
                     $urandom, 4'($urandom), 0);

    test_name = "timer";
    tick(1, 1, 1, 0, 32'd20 + ($urandom % 20), 4'hF, 0);
    tick(1, 1, 2, 0, 32'h1, 4'hF, 0);
    repeat (100) tick(1'($urandom), 1, 4'($urandom % 3), 1, 0, 0, 0);
    for (int c = 0; c < `NB_CORES; c++) tick(1, 2, 4'(4 + c), 1, 0, 0, 0);

    test_name = "event_unit";
    repeat (100) tick(1, 2, 4'($urandom % 12), 1'($urandom), $urandom, 4'($urandom), 1);

    test_name = "back_to_back";
    repeat (250) tick(1, 2'($urandom), 4'($urandom), 1'($urandom), $urandom, 4'($urandom), 1);

    // Drain the last response, then wait for the port to go idle
    tick(0, 0, 0, 1, 0, 0, 0);
    n = 0;
    while (r_valid_o && n < 8) begin
      tick(0, 0, 0, 1, 0, 0, 0);
      n++;
    end
    if (r_valid_o) begin
      errors++;
      $display("Timeout: r_valid_o stayed high after the last request");
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
verilog/cluster_periph_pkg.sv
verilog/periph_bus_if.sv
verilog/periph_addr_decode.sv
verilog/cluster_ctrl_unit.sv
verilog/cluster_timer.sv
verilog/event_unit.sv
verilog/periph_resp_mux.sv
verilog/cluster_periph_top.sv
tests/cluster_periph_chk.sv
tests/cluster_periph_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
( verilator --binary --timing --assert -f sources.f --top-module cluster_periph_tb \
    -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 ) \
  || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }
grep -q "STATUS: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "No pass line in sim.log"; exit 1; }
echo "Simulation passed"
